/* all.f */
source/mem_pkg.sv
source/mem_arbiter.sv
source/pmp_checker.sv
source/sram_memory.sv
source/mem_subsystem.sv
tb/mem_subsystem_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module mem_subsystem_tb \
  -f all.f -o mem_subsystem_sim

./obj_dir/mem_subsystem_sim | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed, see sim.log."
  exit 1
fi

/* source/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              imem_valid,
  input  logic [mem_pkg::mode_width-1:0]    imem_mode,
  input  logic [mem_pkg::addr_width-1:0]    imem_addr,
  output logic                              imem_ready,
  output logic                              imem_error,
  output logic [mem_pkg::data_width-1:0]    imem_rdata,
  input  logic                              dmem_valid,
  input  logic [mem_pkg::mode_width-1:0]    dmem_mode,
  input  logic [mem_pkg::addr_width-1:0]    dmem_addr,
  input  logic [mem_pkg::data_width-1:0]    dmem_wdata,
  input  logic [mem_pkg::strb_width-1:0]    dmem_wstrb,
  output logic                              dmem_ready,
  output logic                              dmem_error,
  output logic [mem_pkg::data_width-1:0]    dmem_rdata,
  output logic                              pmp_valid,
  output logic                              pmp_instr,
  output logic [mem_pkg::mode_width-1:0]    pmp_mode,
  output logic [mem_pkg::addr_width-1:0]    pmp_addr,
  output logic [mem_pkg::strb_width-1:0]    pmp_wstrb,
  input  logic                              pmp_error,
  output logic                              memory_valid,
  output logic [mem_pkg::addr_width-1:0]    memory_addr,
  output logic [mem_pkg::data_width-1:0]    memory_wdata,
  output logic [mem_pkg::strb_width-1:0]    memory_wstrb,
  input  logic [mem_pkg::data_width-1:0]    memory_rdata,
  input  logic                              memory_ready,
  input  logic                              memory_error
);

  import mem_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [access_width-1:0] owner;
  logic                    denied; // Grant was refused by PMP.

  logic                    dbuf_valid;
  logic [mode_width-1:0]   dbuf_mode;
  logic [addr_width-1:0]   dbuf_addr;
  logic [data_width-1:0]   dbuf_wdata;
  logic [strb_width-1:0]   dbuf_wstrb;

  logic [mode_width-1:0]   req_mode;
  logic [addr_width-1:0]   req_addr;
  logic [data_width-1:0]   req_wdata;
  logic [strb_width-1:0]   req_wstrb;

  logic                    transfer_end;
  logic                    free;
  logic                    data_pending;
  logic                    fetch_done;
  logic                    grant_data;
  logic                    grant_instr;
  logic                    hold;

  logic                    sel_instr;
  logic [mode_width-1:0]   sel_mode;
  logic [addr_width-1:0]   sel_addr;
  logic [data_width-1:0]   sel_wdata;
  logic [strb_width-1:0]   sel_wstrb;

  always_comb begin
    transfer_end = memory_ready | memory_error | denied;
    free = (owner == access_none) | transfer_end;
    data_pending = dbuf_valid | dmem_valid;
    // A fetch still held in its own response cycle must not be granted twice.
    fetch_done = (owner == access_instr) & transfer_end;
    grant_data = free & data_pending;
    grant_instr = free & ~data_pending & imem_valid & ~fetch_done;
    hold = (owner != access_none) & ~transfer_end;

    if (grant_data) begin
      sel_instr = 1'b0;
      sel_mode = dbuf_valid ? dbuf_mode : dmem_mode;
      sel_addr = dbuf_valid ? dbuf_addr : dmem_addr;
      sel_wdata = dbuf_valid ? dbuf_wdata : dmem_wdata;
      sel_wstrb = dbuf_valid ? dbuf_wstrb : dmem_wstrb;
    end else if (grant_instr) begin
      sel_instr = 1'b1;
      sel_mode = imem_mode;
      sel_addr = imem_addr;
      sel_wdata = '0;
      sel_wstrb = '0; // Fetches never write.
    end else begin
      sel_instr = (owner == access_instr);
      sel_mode = req_mode;
      sel_addr = req_addr;
      sel_wdata = req_wdata;
      sel_wstrb = req_wstrb;
    end
  end

  assign pmp_valid = grant_data | grant_instr | hold;
  assign pmp_instr = sel_instr;
  assign pmp_mode = sel_mode;
  assign pmp_addr = sel_addr;
  assign pmp_wstrb = sel_wstrb;

  assign memory_valid = pmp_valid & ~pmp_error;
  assign memory_addr = sel_addr;
  assign memory_wdata = sel_wdata;
  assign memory_wstrb = sel_wstrb;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      owner <= access_none;
      denied <= 1'b0;
      dbuf_valid <= 1'b0;
    end else begin
      denied <= (grant_data | grant_instr) & pmp_error;
      if (grant_data) begin
        owner <= access_data;
      end else if (grant_instr) begin
        owner <= access_instr;
      end else if (transfer_end) begin
        owner <= access_none;
      end
      if (grant_data) begin
        dbuf_valid <= 1'b0;
      end else if (dmem_valid) begin
        dbuf_valid <= 1'b1; // Keep the pulse while the memory is busy.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dmem_valid) begin
      dbuf_mode <= dmem_mode;
      dbuf_addr <= dmem_addr;
      dbuf_wdata <= dmem_wdata;
      dbuf_wstrb <= dmem_wstrb;
    end
    if (grant_data | grant_instr) begin
      req_mode <= sel_mode;
      req_addr <= sel_addr;
      req_wdata <= sel_wdata;
      req_wstrb <= sel_wstrb;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign imem_ready = (owner == access_instr) & transfer_end;
  assign imem_error = (owner == access_instr) & (denied | memory_error);
  assign imem_rdata = ((owner == access_instr) && memory_ready && !denied) ? memory_rdata : '0;

  assign dmem_ready = (owner == access_data) & transfer_end;
  assign dmem_error = (owner == access_data) & (denied | memory_error);
  assign dmem_rdata = ((owner == access_data) && memory_ready && !denied) ? memory_rdata : '0;

  a_response_owned: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    (memory_ready || memory_error) |-> (owner != access_none)
  ) else $error("Memory answered with no owner to steer the response to.");

  a_hold_permitted: assert property (
    @(posedge clock) disable iff (reset == 1'b0) hold |-> !pmp_error
  ) else $error("Request held toward the memory was denied by PMP.");

  a_buffer_overwrite: assert property (
    @(posedge clock) disable iff (reset == 1'b0) dmem_valid |-> !dbuf_valid
  ) else $error("Data request arrived with the buffer full.");

endmodule

/* source/mem_pkg.sv */
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = 4;
  localparam int mode_width = 2;
  localparam int access_width = 2;
  localparam int perm_width = 3;

  // Privilege modes.
  localparam logic [mode_width-1:0] mode_user = 2'd0;
  localparam logic [mode_width-1:0] mode_machine = 2'd3;

  // Owner of the memory.
  localparam logic [access_width-1:0] access_none = 2'd0;
  localparam logic [access_width-1:0] access_instr = 2'd1;
  localparam logic [access_width-1:0] access_data = 2'd2;

  // Permission bits.
  localparam logic [perm_width-1:0] perm_read = 3'b001;
  localparam logic [perm_width-1:0] perm_write = 3'b010;
  localparam logic [perm_width-1:0] perm_execute = 3'b100;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PMP region table with exclusive limits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int pmp_regions = 4;

  localparam logic [addr_width-1:0] pmp_region_base [0:pmp_regions-1] = '{
    32'h0000_0000,
    32'h0000_0400,
    32'h0000_0800,
    32'h0000_0000
  };

  localparam logic [addr_width-1:0] pmp_region_limit [0:pmp_regions-1] = '{
    32'h0000_0400,
    32'h0000_0800,
    32'h0000_0c00,
    32'h0000_0000 // Empty region.
  };

  localparam logic [perm_width-1:0] pmp_region_perm [0:pmp_regions-1] = '{
    perm_execute | perm_read,
    perm_read | perm_write,
    perm_read,
    3'b000
  };

endpackage

/* source/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem #(
  parameter int memory_latency = 2,
  parameter int memory_depth = 1024
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           imem_valid,
  input  logic [mem_pkg::mode_width-1:0] imem_mode,
  input  logic [mem_pkg::addr_width-1:0] imem_addr,
  output logic                           imem_ready,
  output logic                           imem_error,
  output logic [mem_pkg::data_width-1:0] imem_rdata,
  input  logic                           dmem_valid,
  input  logic [mem_pkg::mode_width-1:0] dmem_mode,
  input  logic [mem_pkg::addr_width-1:0] dmem_addr,
  input  logic [mem_pkg::data_width-1:0] dmem_wdata,
  input  logic [mem_pkg::strb_width-1:0] dmem_wstrb,
  output logic                           dmem_ready,
  output logic                           dmem_error,
  output logic [mem_pkg::data_width-1:0] dmem_rdata
);

  import mem_pkg::*;

  // Arbiter to PMP.
  logic                  pmp_valid;
  logic                  pmp_instr;
  logic [mode_width-1:0] pmp_mode;
  logic [addr_width-1:0] pmp_addr;
  logic [strb_width-1:0] pmp_wstrb;
  logic                  pmp_error;

  // Arbiter to memory.
  logic                  memory_valid;
  logic [addr_width-1:0] memory_addr;
  logic [data_width-1:0] memory_wdata;
  logic [strb_width-1:0] memory_wstrb;
  logic [data_width-1:0] memory_rdata;
  logic                  memory_ready;
  logic                  memory_error;

  mem_arbiter arbiter_i (.*);

  pmp_checker pmp_i (
    .pmp_valid (pmp_valid),
    .pmp_instr (pmp_instr),
    .pmp_mode  (pmp_mode),
    .pmp_addr  (pmp_addr),
    .pmp_wstrb (pmp_wstrb),
    .pmp_error (pmp_error)
  );

  sram_memory #(
    .latency (memory_latency),
    .depth   (memory_depth)
  ) memory_i (
    .clock        (clock),
    .reset        (reset),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready),
    .memory_error (memory_error)
  );

endmodule

/* source/pmp_checker.sv */
`timescale 1ns/10ps

module pmp_checker (
  input  logic                           pmp_valid,
  input  logic                           pmp_instr,
  input  logic [mem_pkg::mode_width-1:0] pmp_mode,
  input  logic [mem_pkg::addr_width-1:0] pmp_addr,
  input  logic [mem_pkg::strb_width-1:0] pmp_wstrb,
  output logic                           pmp_error
);

  import mem_pkg::*;

  logic [perm_width-1:0] need;
  logic [perm_width-1:0] granted;
  logic                  hit;
  logic                  allowed;

  // Permission the access asks for.
  always_comb begin
    if (pmp_instr) begin
      need = perm_execute;
    end else if (|pmp_wstrb) begin
      need = perm_write;
    end else begin
      need = perm_read;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Region match with the lowest entry first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    hit = 1'b0;
    granted = '0;
    for (int i = 0; i < pmp_regions; i++) begin
      if (!hit && pmp_addr >= pmp_region_base[i] && pmp_addr < pmp_region_limit[i]) begin
        hit = 1'b1;
        granted = pmp_region_perm[i];
      end
    end
  end

  always_comb begin
    if (pmp_mode == mode_machine) begin
      allowed = 1'b1; // No table check.
    end else begin
      allowed = hit && ((granted & need) != '0);
    end
  end

  assign pmp_error = pmp_valid & ~allowed;

  always_comb begin
    if (pmp_valid) begin
      assert (pmp_mode == mode_user || pmp_mode == mode_machine)
        else $error("PMP request with an unsupported privilege mode.");
    end
  end

endmodule

/* source/sram_memory.sv */
`timescale 1ns/10ps

module sram_memory #(
  parameter int latency = 2,
  parameter int depth = 1024
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           memory_valid,
  input  logic [mem_pkg::addr_width-1:0] memory_addr,
  input  logic [mem_pkg::data_width-1:0] memory_wdata,
  input  logic [mem_pkg::strb_width-1:0] memory_wstrb,
  output logic [mem_pkg::data_width-1:0] memory_rdata,
  output logic                           memory_ready,
  output logic                           memory_error
);

  import mem_pkg::*;

  localparam int offset_bits = $clog2(strb_width);
  localparam int index_bits = $clog2(depth);
  localparam int count_width = $clog2(latency + 1);

  logic [data_width-1:0]             mem [0:depth-1];
  logic [count_width-1:0]            count;
  logic [addr_width-offset_bits-1:0] word_index;
  logic                              in_range;
  logic                              finish;

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  assign word_index = memory_addr[addr_width-1:offset_bits];
  assign in_range = (word_index < depth);
  assign finish = (count == count_width'(1));

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      count <= '0;
      memory_ready <= 1'b0;
      memory_error <= 1'b0;
      memory_rdata <= '0;
    end else begin
      memory_ready <= 1'b0;
      memory_error <= 1'b0;
      if (count == '0) begin
        if (memory_valid) begin
          count <= count_width'(latency); // New access.
        end
      end else begin
        count <= count - 1'b1;
        if (finish) begin
          memory_ready <= in_range;
          memory_error <= ~in_range;
          memory_rdata <= in_range ? mem[memory_addr[index_bits+offset_bits-1:offset_bits]] : '0;
        end
      end
    end
  end

  // Write lands with the response after the read above.
  always_ff @(posedge clock) begin
    if (finish && in_range) begin
      for (int b = 0; b < strb_width; b++) begin
        if (memory_wstrb[b]) begin
          mem[memory_addr[index_bits+offset_bits-1:offset_bits]][8*b +: 8] <=
            memory_wdata[8*b +: 8];
        end
      end
    end
  end

  a_addr_stable: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    (count != '0) |-> (memory_valid && $stable(memory_addr))
  ) else $error("Request changed before the memory answered.");

endmodule

/* tb/mem_subsystem_tb.sv */
`timescale 1ns/10ps

module mem_subsystem_tb;

  import mem_pkg::*;

  localparam int memory_latency = 2;
  localparam int memory_depth = 1024;
  localparam int memory_bytes = memory_depth * strb_width;
  localparam int timeout_cycles = 50;
  localparam bit port_data = 1'b0;
  localparam bit port_fetch = 1'b1;

  typedef struct {
    string                 name;
    bit                    fetch;
    logic [mode_width-1:0] mode;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic [data_width-1:0] exp_rdata;
    logic                  exp_error;
    int                    exp_cycles;
  } test_entry_t;

  logic                  clock;
  logic                  reset;
  logic                  imem_valid;
  logic [mode_width-1:0] imem_mode;
  logic [addr_width-1:0] imem_addr;
  logic                  imem_ready;
  logic                  imem_error;
  logic [data_width-1:0] imem_rdata;
  logic                  dmem_valid;
  logic [mode_width-1:0] dmem_mode;
  logic [addr_width-1:0] dmem_addr;
  logic [data_width-1:0] dmem_wdata;
  logic [strb_width-1:0] dmem_wstrb;
  logic                  dmem_ready;
  logic                  dmem_error;
  logic [data_width-1:0] dmem_rdata;

  test_entry_t           tests [$];
  logic [data_width-1:0] ref_mem [0:memory_depth-1]; // Expected memory contents.
  int                    seed;
  int                    pass_count;
  int                    fail_count;
  bit                    timed_out;

  mem_subsystem #(
    .memory_latency (memory_latency),
    .memory_depth   (memory_depth)
  ) dut_i (.*);

  always #20 clock = ~clock;

  function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_word,
                                                        input logic [data_width-1:0] new_word,
                                                        input logic [strb_width-1:0] strb);
    logic [data_width-1:0] result;
    result = old_word;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Access rule of the region table.
  function automatic bit pmp_denies(input bit fetch, input logic [mode_width-1:0] mode,
                                    input logic [addr_width-1:0] addr,
                                    input logic [strb_width-1:0] wstrb);
    logic [perm_width-1:0] need;
    need = fetch ? perm_execute : ((wstrb != '0) ? perm_write : perm_read);
    if (mode == mode_machine) begin
      return 1'b0;
    end
    for (int r = 0; r < pmp_regions; r++) begin
      if (addr >= pmp_region_base[r] && addr < pmp_region_limit[r]) begin
        return (pmp_region_perm[r] & need) == '0; // First match decides.
      end
    end
    return 1'b1;
  endfunction

  task automatic add_entry(input string name, input bit fetch, input logic [mode_width-1:0] mode,
                           input logic [addr_width-1:0] addr, input logic [data_width-1:0] wdata,
                           input logic [strb_width-1:0] wstrb);
    test_entry_t t;
    bit denied;
    t.name = name;
    t.fetch = fetch;
    t.mode = mode;
    t.addr = addr;
    t.wdata = wdata;
    t.wstrb = fetch ? '0 : wstrb;
    denied = pmp_denies(fetch, mode, addr, t.wstrb);
    t.exp_error = denied || (addr >= memory_bytes);
    t.exp_cycles = denied ? 1 : memory_latency + 1;
    t.exp_rdata = '0;
    if (!t.exp_error) begin
      t.exp_rdata = ref_mem[addr >> 2]; // Read sees the word before the write.
      ref_mem[addr >> 2] = merge_bytes(ref_mem[addr >> 2], wdata, t.wstrb);
    end
    tests.push_back(t);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic build_table();
    add_entry("m_write_full", port_data, mode_machine, 32'h0000_0100, 32'h1122_3344, 4'hf);
    add_entry("m_write_low_half", port_data, mode_machine, 32'h0000_0100, 32'haaaa_bbbb, 4'h3);
    add_entry("m_write_byte2", port_data, mode_machine, 32'h0000_0100, 32'h00cc_0000, 4'h4);
    add_entry("m_read_merged", port_data, mode_machine, 32'h0000_0100, '0, 4'h0);
    add_entry("m_write_random", port_data, mode_machine, 32'h0000_0104, $random(seed), 4'hf);
    add_entry("m_write_random_part", port_data, mode_machine, 32'h0000_0104, $random(seed), 4'h9);
    add_entry("m_read_random", port_data, mode_machine, 32'h0000_0104, '0, 4'h0);
    add_entry("m_fetch_written", port_fetch, mode_machine, 32'h0000_0100, '0, 4'h0);
    add_entry("m_write_region2", port_data, mode_machine, 32'h0000_0810, 32'h5a5a_0f0f, 4'hf);
    add_entry("u_fetch_region0", port_fetch, mode_user, 32'h0000_0100, '0, 4'h0);
    add_entry("u_write_region1", port_data, mode_user, 32'h0000_0440, $random(seed), 4'hf);
    add_entry("u_read_region1", port_data, mode_user, 32'h0000_0440, '0, 4'h0);
    add_entry("u_write_region2", port_data, mode_user, 32'h0000_0810, 32'hdead_beef, 4'hf);
    add_entry("u_fetch_region1", port_fetch, mode_user, 32'h0000_0440, '0, 4'h0);
    add_entry("u_read_unmapped", port_data, mode_user, 32'h0000_0c00, '0, 4'h0);
    add_entry("m_read_region2", port_data, mode_machine, 32'h0000_0810, '0, 4'h0);
    add_entry("m_write_beyond", port_data, mode_machine, 32'h0000_1000, 32'hffff_ffff, 4'hf);
    add_entry("m_read_beyond", port_data, mode_machine, 32'h0000_1004, '0, 4'h0);
    add_entry("m_read_alias", port_data, mode_machine, 32'h0000_0000, '0, 4'h0);
    add_entry("m_fetch_beyond", port_fetch, mode_machine, 32'h0000_2000, '0, 4'h0);
  endtask

  task automatic reset_and_check_idle();
    bit quiet;
    quiet = 1'b1;
    for (int c = 0; c < 11; c++) begin
      @(posedge clock);
      if (c == 7) begin
        #1;
        reset = 1'b1; // Eight edges seen with reset low.
      end
      @(negedge clock);
      if ({imem_ready, imem_error, dmem_ready, dmem_error} !== 4'b0000) begin
        quiet = 1'b0;
      end
    end
    if (!quiet) begin
      $display("FAILED at %t: reset_idle, a ready or error output was not low", $time);
      fail_count++;
    end else begin
      $display("passed reset_idle");
      pass_count++;
    end
  endtask

  // Returns at the falling edge where the port's ready is high.
  task automatic wait_ready(input bit fetch, output bit seen, output int waited,
                            output bit stray);
    seen = 1'b0;
    waited = 0;
    stray = 1'b0;
    while (!seen && waited < timeout_cycles) begin
      @(negedge clock);
      if ((fetch && dmem_ready === 1'b1) || (!fetch && imem_ready === 1'b1)) begin
        stray = 1'b1;
      end
      if ((fetch && imem_ready === 1'b1) || (!fetch && dmem_ready === 1'b1)) begin
        seen = 1'b1;
      end else begin
        waited++;
        @(posedge clock);
        #1;
        dmem_valid = 1'b0; // Data request is a single pulse.
      end
    end
  endtask

  task automatic run_entry(input test_entry_t t);
    bit                    seen;
    bit                    stray;
    int                    waited;
    logic [data_width-1:0] got_rdata;
    logic                  got_error;
    string                 msg;
    @(posedge clock);
    #1;
    if (t.fetch) begin
      imem_valid = 1'b1;
      imem_mode = t.mode;
      imem_addr = t.addr;
    end else begin
      dmem_valid = 1'b1;
      dmem_mode = t.mode;
      dmem_addr = t.addr;
      dmem_wdata = t.wdata;
      dmem_wstrb = t.wstrb;
    end
    wait_ready(t.fetch, seen, waited, stray);
    got_rdata = t.fetch ? imem_rdata : dmem_rdata;
    got_error = t.fetch ? imem_error : dmem_error;
    msg = "";
    if (!seen) begin
      $display("%s: no ready within %0d cycles, the test timed out", t.name, timeout_cycles);
      timed_out = 1'b1;
      fail_count++;
    end else begin
      if (got_error !== t.exp_error) begin
        msg = {msg, $sformatf(" error %b expected %b", got_error, t.exp_error)};
      end
      if (got_rdata !== t.exp_rdata) begin
        msg = {msg, $sformatf(" rdata %h expected %h", got_rdata, t.exp_rdata)};
      end
      if (waited != t.exp_cycles) begin
        msg = {msg, $sformatf(" after %0d cycles expected %0d", waited, t.exp_cycles)};
      end
      if (stray) begin
        msg = {msg, " ready also seen on the other port"};
      end
      if (msg != "") begin
        $display("FAILED at %t: %s%s", $time, t.name, msg);
        fail_count++;
      end else begin
        $display("passed %s", t.name);
        pass_count++;
      end
    end
    @(posedge clock);
    #1;
    imem_valid = 1'b0;
    dmem_valid = 1'b0;
  endtask

  // Fetch held while a data write to the same word arrives.
  task automatic run_contention();
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] exp_data_rdata;
    logic [data_width-1:0] exp_fetch_rdata;
    bit                    data_seen;
    bit                    fetch_seen;
    int                    waited;
    string                 msg;
    addr = 32'h0000_0108;
    wdata = $random(seed);
    exp_data_rdata = ref_mem[addr >> 2];
    ref_mem[addr >> 2] = merge_bytes(ref_mem[addr >> 2], wdata, 4'hf);
    exp_fetch_rdata = ref_mem[addr >> 2]; // Fetch goes second and sees the write.
    data_seen = 1'b0;
    fetch_seen = 1'b0;
    waited = 0;
    msg = "";
    @(posedge clock);
    #1;
    imem_valid = 1'b1;
    imem_mode = mode_machine;
    imem_addr = addr;
    dmem_valid = 1'b1;
    dmem_mode = mode_machine;
    dmem_addr = addr;
    dmem_wdata = wdata;
    dmem_wstrb = 4'hf;
    @(posedge clock);
    #1;
    dmem_valid = 1'b0;
    while (!(data_seen && fetch_seen) && waited < timeout_cycles) begin
      @(negedge clock);
      waited++;
      if (imem_ready === 1'b1) begin
        if (!data_seen) begin
          msg = {msg, " fetch answered before data"};
        end
        if (imem_error !== 1'b0 || imem_rdata !== exp_fetch_rdata) begin
          msg = {msg, $sformatf(" fetch rdata %h error %b expected %h", imem_rdata, imem_error,
                                exp_fetch_rdata)};
        end
        fetch_seen = 1'b1;
      end
      if (dmem_ready === 1'b1) begin
        if (dmem_error !== 1'b0 || dmem_rdata !== exp_data_rdata) begin
          msg = {msg, $sformatf(" data rdata %h error %b expected %h", dmem_rdata, dmem_error,
                                exp_data_rdata)};
        end
        data_seen = 1'b1;
      end
    end
    @(posedge clock);
    #1;
    imem_valid = 1'b0;
    if (!(data_seen && fetch_seen)) begin
      $display("fetch_behind_data: a response never came within %0d cycles, the test timed out",
               timeout_cycles);
      timed_out = 1'b1;
      fail_count++;
    end else if (msg != "") begin
      $display("FAILED at %t: fetch_behind_data%s", $time, msg);
      fail_count++;
    end else begin
      $display("passed fetch_behind_data");
      pass_count++;
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed = 32'h80fa_cbba;
    clock = 1'b0;
    reset = 1'b0;
    imem_valid = 1'b0;
    imem_mode = mode_machine;
    imem_addr = '0;
    dmem_valid = 1'b0;
    dmem_mode = mode_machine;
    dmem_addr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    pass_count = 0;
    fail_count = 0;
    timed_out = 1'b0;
    for (int i = 0; i < memory_depth; i++) begin
      ref_mem[i] = '0;
    end
    build_table();
    reset_and_check_idle();
    for (int i = 0; i < tests.size() && !timed_out; i++) begin
      run_entry(tests[i]);
    end
    if (!timed_out) begin
      run_contention();
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
